// File: logic/led_params.svh
// panel geometry, colour depth and timing constants
// shared by the led panel design
`ifndef LED_PARAMS_SVH
`define LED_PARAMS_SVH

// panel geometry
`define PANEL_COLS 16
`define PANEL_ROWS 8
`define HALF_ROWS 4
`define COL_BITS 4
`define ROW_BITS 2

// colour depth, one bit plane per colour bit
`define COLOR_BITS 2
`define PLANES 2

// serial link
`define UART_TICKS_PER_BIT 8

// scan timing
`define SCAN_DIV 4 // clk_root cycles per scan tick
`define SHOW_UNIT 8 // ticks shown for plane 0

`endif

// File: logic/panel_pkg.sv
// panel side types: pixels, framebuffer addressing,
// scan states and the bundle of panel drive pins
`include "led_params.svh"

package panel_pkg;

    typedef struct packed {
        logic [`COLOR_BITS-1:0] blue;
        logic [`COLOR_BITS-1:0] green;
        logic [`COLOR_BITS-1:0] red; // low bits
    } pixel_t;

    // one framebuffer word covers both halves of the panel
    typedef struct packed {
        pixel_t bottom;
        pixel_t top;
    } pixel_pair_t;

    typedef struct packed {
        logic                 half; // 1 = bottom half
        logic [`ROW_BITS-1:0] row;
        logic [`COL_BITS-1:0] col;
    } fb_addr_t;

    typedef enum logic [1:0] {
        SHIFT,
        LATCH,
        SHOW
    } scan_state_t;

    typedef struct packed {
        logic [2:0]           rgb_top; // red at bit 0
        logic [2:0]           rgb_bottom;
        logic [`ROW_BITS-1:0] row_addr;
        logic                 clk_pixel;
        logic                 latch;
        logic                 output_enable; // active high
        logic                 spare; // reserved, always 0
    } panel_drive_t;

endpackage

// File: logic/cmd_pkg.sv
// command side types: opcodes, decoder states
// and the framebuffer write bundle
package cmd_pkg;

    // opcodes are plain ascii letters
    typedef enum logic [7:0] {
        OP_PIXEL  = 8'h50, // 'P'
        OP_RGB_EN = 8'h45, // 'E'
        OP_BRIGHT = 8'h42  // 'B'
    } opcode_t;

    typedef enum logic [1:0] {
        IDLE,
        ADDR,
        DATA,
        ARG
    } dec_state_t;

    typedef struct packed {
        logic                strobe; // one cycle per write
        panel_pkg::fb_addr_t addr;
        panel_pkg::pixel_t   pixel;
    } fb_write_t;

endpackage

// File: logic/uart_rx.sv
// 8N1 serial receiver, samples each bit in the middle
// and pulses byte_valid for one cycle per good frame
`timescale 1ns/1ps
`include "led_params.svh"

module uart_rx (
    input  logic       clk_root,
    input  logic       rst,
    input  logic       uart_line,
    output logic [7:0] byte_data,
    output logic       byte_valid
);
    localparam int TICK_W = $clog2(`UART_TICKS_PER_BIT);

    logic [1:0]        line_sync;
    logic              rx_bit;
    logic              busy;
    logic [3:0]        bit_idx; // 0 start, 1..8 data, 9 stop
    logic [TICK_W-1:0] tick_cnt;
    logic [7:0]        shift_reg;

    assign rx_bit    = line_sync[1];
    assign byte_data = shift_reg;

    always_ff @(posedge clk_root) begin
        if (rst) begin
            line_sync <= 2'b11; // line idles high
        end else begin
            line_sync <= {line_sync[0], uart_line};
        end
    end

    always_ff @(posedge clk_root) begin
        if (rst) begin
            busy       <= 1'b0;
            bit_idx    <= '0;
            tick_cnt   <= '0;
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            if (!busy) begin
                if (!rx_bit) begin
                    busy     <= 1'b1;
                    bit_idx  <= '0;
                    // half a bit, less the two sync stages
                    tick_cnt <= TICK_W'(`UART_TICKS_PER_BIT / 2 - 2);
                end
            end else if (tick_cnt != '0) begin
                tick_cnt <= tick_cnt - 1'b1;
            end else begin
                tick_cnt <= TICK_W'(`UART_TICKS_PER_BIT - 1);
                bit_idx  <= bit_idx + 1'b1;
                if (bit_idx == 4'd0 && rx_bit) begin
                    busy <= 1'b0; // start bit glitch
                end else if (bit_idx == 4'd9) begin
                    busy       <= 1'b0;
                    byte_valid <= rx_bit; // framing error drops the byte
                end
            end
        end
    end

    // lsb first
    always_ff @(posedge clk_root) begin
        if (busy && tick_cnt == '0 && bit_idx >= 4'd1 && bit_idx <= 4'd8) begin
            shift_reg <= {rx_bit, shift_reg[7:1]};
        end
    end

    a_single_strobe: assert property (
        @(posedge clk_root) disable iff (rst) byte_valid |=> !byte_valid
    );

endmodule

// File: logic/cmd_decoder.sv
// command parser: turns the received byte stream into
// framebuffer writes and the colour / plane enable levels
`timescale 1ns/1ps
`include "led_params.svh"

module cmd_decoder (
    input  logic                clk_root,
    input  logic                rst,
    input  logic [7:0]          byte_data,
    input  logic                byte_valid,
    output cmd_pkg::fb_write_t  fb_write,
    output logic [2:0]          rgb_enable,
    output logic [`PLANES-1:0]  plane_enable
);
    cmd_pkg::dec_state_t state;
    cmd_pkg::opcode_t    opcode; // which single-argument command is pending
    panel_pkg::fb_addr_t addr;
    logic                wr_strobe;
    panel_pkg::fb_addr_t wr_addr;
    panel_pkg::pixel_t   wr_pixel;

    always_ff @(posedge clk_root) begin
        if (rst) begin
            state        <= cmd_pkg::IDLE;
            opcode       <= cmd_pkg::OP_PIXEL;
            wr_strobe    <= 1'b0;
            rgb_enable   <= '1;
            plane_enable <= '1;
        end else begin
            wr_strobe <= 1'b0;
            if (byte_valid) begin
                case (state)
                    cmd_pkg::IDLE: begin
                        case (cmd_pkg::opcode_t'(byte_data))
                            cmd_pkg::OP_PIXEL: begin
                                state <= cmd_pkg::ADDR;
                            end
                            cmd_pkg::OP_RGB_EN, cmd_pkg::OP_BRIGHT: begin
                                opcode <= cmd_pkg::opcode_t'(byte_data);
                                state  <= cmd_pkg::ARG;
                            end
                            default: state <= cmd_pkg::IDLE; // unknown byte
                        endcase
                    end
                    cmd_pkg::ADDR: state <= cmd_pkg::DATA;
                    cmd_pkg::DATA: begin
                        wr_strobe <= 1'b1;
                        state     <= cmd_pkg::IDLE;
                    end
                    cmd_pkg::ARG: begin
                        if (opcode == cmd_pkg::OP_RGB_EN) begin
                            rgb_enable <= byte_data[2:0];
                        end else begin
                            plane_enable <= byte_data[`PLANES-1:0];
                        end
                        state <= cmd_pkg::IDLE;
                    end
                    default: state <= cmd_pkg::IDLE;
                endcase
            end
        end
    end

    // address and pixel payload
    always_ff @(posedge clk_root) begin
        if (byte_valid && state == cmd_pkg::ADDR) begin
            addr <= panel_pkg::fb_addr_t'(byte_data[6:0]);
        end
        if (byte_valid && state == cmd_pkg::DATA) begin
            wr_addr  <= addr;
            wr_pixel <= panel_pkg::pixel_t'(byte_data[5:0]);
        end
    end

    assign fb_write = '{strobe: wr_strobe, addr: wr_addr, pixel: wr_pixel};

    a_write_after_data: assert property (
        @(posedge clk_root) disable iff (rst)
        fb_write.strobe |-> $past(byte_valid && state == cmd_pkg::DATA)
    );

endmodule

// File: logic/frame_ram.sv
// framebuffer, one pixel pair per word
// writes touch one half of a word, reads return the whole pair
`timescale 1ns/1ps
`include "led_params.svh"

module frame_ram (
    input  logic                   clk_root,
    input  cmd_pkg::fb_write_t     fb_write,
    input  logic [`ROW_BITS-1:0]   rd_row,
    input  logic [`COL_BITS-1:0]   rd_col,
    output panel_pkg::pixel_pair_t rd_data
);
    localparam int DEPTH = `HALF_ROWS * `PANEL_COLS;
    localparam int IDX_W = `ROW_BITS + `COL_BITS;

    panel_pkg::pixel_pair_t mem [DEPTH];
    logic [IDX_W-1:0]       wr_idx;
    logic [IDX_W-1:0]       rd_idx;

    assign wr_idx = {fb_write.addr.row, fb_write.addr.col};
    assign rd_idx = {rd_row, rd_col};

    always_ff @(posedge clk_root) begin
        if (fb_write.strobe) begin
            if (fb_write.addr.half) begin
                mem[wr_idx].bottom <= fb_write.pixel;
            end else begin
                mem[wr_idx].top <= fb_write.pixel;
            end
        end
        rd_data <= mem[rd_idx]; // old data on a same-cycle write
    end

endmodule

// File: logic/matrix_scan.sv
// scan engine: tick divider plus shift / latch / show sequencing
// with binary weighted show time per bit plane
`timescale 1ns/1ps
`include "led_params.svh"

module matrix_scan (
    input  logic                        clk_root,
    input  logic                        rst,
    input  logic [2:0]                  rgb_top,
    input  logic [2:0]                  rgb_bottom,
    output logic                        load_strobe,
    output logic [`COL_BITS-1:0]        column,
    output logic [`ROW_BITS-1:0]        row,
    output logic [$clog2(`PLANES)-1:0]  plane,
    output panel_pkg::panel_drive_t     panel
);
    localparam int DIV_W   = $clog2(`SCAN_DIV);
    localparam int SHOW_W  = $clog2(`SHOW_UNIT << (`PLANES - 1));
    localparam int PLANE_W = $clog2(`PLANES);

    panel_pkg::scan_state_t state;
    logic [DIV_W-1:0]       div_cnt;
    logic                   tick_end;
    logic                   phase; // 0 data setup tick, 1 clk_pixel tick
    logic [SHOW_W-1:0]      show_cnt;
    logic [`ROW_BITS-1:0]   row_addr; // row currently driven on the panel

    assign tick_end = (div_cnt == DIV_W'(`SCAN_DIV - 1));

    always_ff @(posedge clk_root) begin
        if (rst) begin
            div_cnt <= '0;
        end else if (tick_end) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk_root) begin
        if (rst) begin
            state    <= panel_pkg::SHIFT;
            phase    <= 1'b0;
            column   <= '0;
            row      <= '0;
            plane    <= '0;
            show_cnt <= '0;
            row_addr <= '0;
        end else if (tick_end) begin
            case (state)
                panel_pkg::SHIFT: begin
                    phase <= ~phase;
                    if (phase) begin
                        if (column == `COL_BITS'(`PANEL_COLS - 1)) begin
                            column   <= '0;
                            row_addr <= row; // visible during the latch tick
                            state    <= panel_pkg::LATCH;
                        end else begin
                            column <= column + 1'b1;
                        end
                    end
                end
                panel_pkg::LATCH: begin
                    show_cnt <= SHOW_W'((`SHOW_UNIT << plane) - 1);
                    state    <= panel_pkg::SHOW;
                end
                panel_pkg::SHOW: begin
                    show_cnt <= show_cnt - 1'b1;
                    if (show_cnt == '0) begin
                        state <= panel_pkg::SHIFT;
                        // all planes of a row, then the next row
                        if (plane == PLANE_W'(`PLANES - 1)) begin
                            plane <= '0;
                            row   <= row + 1'b1;
                        end else begin
                            plane <= plane + 1'b1;
                        end
                    end
                end
                default: state <= panel_pkg::SHIFT;
            endcase
        end
    end

    // fetch kicks off on the first cycle of each column
    assign load_strobe = (state == panel_pkg::SHIFT) && !phase && (div_cnt == '0);

    always_comb begin
        panel               = '0;
        panel.rgb_top       = rgb_top;
        panel.rgb_bottom    = rgb_bottom;
        panel.row_addr      = row_addr;
        panel.clk_pixel     = (state == panel_pkg::SHIFT) && phase;
        panel.latch         = (state == panel_pkg::LATCH);
        panel.output_enable = (state == panel_pkg::SHOW);
    end

    a_oe_exclusive: assert property (
        @(posedge clk_root) disable iff (rst)
        panel.output_enable |-> !(panel.clk_pixel || panel.latch)
    );

endmodule

// File: logic/frame_fetch.sv
// pixel fetch: reads the pair for the current column and reduces
// each half to one bit per colour for the active plane
`timescale 1ns/1ps
`include "led_params.svh"

module frame_fetch (
    input  logic                        clk_root,
    input  logic                        rst,
    input  logic                        load_strobe,
    input  logic [`COL_BITS-1:0]        column,
    input  logic [`ROW_BITS-1:0]        row,
    input  logic [$clog2(`PLANES)-1:0]  plane,
    input  logic [2:0]                  rgb_enable,
    input  logic [`PLANES-1:0]          plane_enable,
    output logic [`ROW_BITS-1:0]        rd_row,
    output logic [`COL_BITS-1:0]        rd_col,
    input  panel_pkg::pixel_pair_t      rd_data,
    output logic [2:0]                  rgb_top,
    output logic [2:0]                  rgb_bottom
);
    localparam int PLANE_W = $clog2(`PLANES);

    logic               load_d; // ram data valid
    logic [PLANE_W-1:0] plane_d;

    // one bit per channel, red at bit 0, masked by both enables
    function automatic logic [2:0] plane_bits(
        input panel_pkg::pixel_t  px,
        input logic [PLANE_W-1:0] pl
    );
        logic [2:0] bits;
        bits[0] = px.red[pl];
        bits[1] = px.green[pl];
        bits[2] = px.blue[pl];
        return bits & rgb_enable & {3{plane_enable[pl]}};
    endfunction

    // read address follows the scan, ram answers next cycle
    assign rd_row = row;
    assign rd_col = column;

    always_ff @(posedge clk_root) begin
        if (load_strobe) begin
            plane_d <= plane;
        end
    end

    always_ff @(posedge clk_root) begin
        if (rst) begin
            load_d     <= 1'b0;
            rgb_top    <= '0;
            rgb_bottom <= '0;
        end else begin
            load_d <= load_strobe;
            if (load_d) begin
                rgb_top    <= plane_bits(rd_data.top, plane_d);
                rgb_bottom <= plane_bits(rd_data.bottom, plane_d);
            end
        end
    end

endmodule

// File: logic/led_panel_top.sv
// led panel controller top: uart commands in, hub75 style drive out
// receiver -> decoder -> framebuffer, scan -> fetch -> panel
`timescale 1ns/1ps
`include "led_params.svh"

module led_panel_top (
    input  logic                    clk_root,
    input  logic                    rst,
    input  logic                    uart_line,
    output panel_pkg::panel_drive_t panel
);
    logic [7:0]                 byte_data;
    logic                       byte_valid;
    cmd_pkg::fb_write_t         fb_write;
    logic [2:0]                 rgb_enable;
    logic [`PLANES-1:0]         plane_enable;
    logic [`ROW_BITS-1:0]       rd_row;
    logic [`COL_BITS-1:0]       rd_col;
    panel_pkg::pixel_pair_t     rd_data;
    logic                       load_strobe;
    logic [`COL_BITS-1:0]       column;
    logic [`ROW_BITS-1:0]       row;
    logic [$clog2(`PLANES)-1:0] plane;
    logic [2:0]                 rgb_top;
    logic [2:0]                 rgb_bottom;

    uart_rx i_uart_rx (
        .clk_root   (clk_root),
        .rst        (rst),
        .uart_line  (uart_line),
        .byte_data  (byte_data),
        .byte_valid (byte_valid)
    );

    cmd_decoder i_cmd_decoder (
        .clk_root     (clk_root),
        .rst          (rst),
        .byte_data    (byte_data),
        .byte_valid   (byte_valid),
        .fb_write     (fb_write),
        .rgb_enable   (rgb_enable),
        .plane_enable (plane_enable)
    );

    frame_ram i_frame_ram (
        .clk_root (clk_root),
        .fb_write (fb_write),
        .rd_row   (rd_row),
        .rd_col   (rd_col),
        .rd_data  (rd_data)
    );

    matrix_scan i_matrix_scan (
        .clk_root    (clk_root),
        .rst         (rst),
        .rgb_top     (rgb_top),
        .rgb_bottom  (rgb_bottom),
        .load_strobe (load_strobe),
        .column      (column),
        .row         (row),
        .plane       (plane),
        .panel       (panel)
    );

    frame_fetch i_frame_fetch (
        .clk_root     (clk_root),
        .rst          (rst),
        .load_strobe  (load_strobe),
        .column       (column),
        .row          (row),
        .plane        (plane),
        .rgb_enable   (rgb_enable),
        .plane_enable (plane_enable),
        .rd_row       (rd_row),
        .rd_col       (rd_col),
        .rd_data      (rd_data),
        .rgb_top      (rgb_top),
        .rgb_bottom   (rgb_bottom)
    );

endmodule

// File: tests/tb_led_panel.sv
// testbench for the led panel controller
// sends uart commands from a table and checks every shifted row pair
`timescale 1ns/1ps
`include "led_params.svh"

module tb_led_panel;
    localparam int NUM_TESTS = 7;
    localparam int PASS_MAX = `PANEL_COLS * 2 * `SCAN_DIV + `SCAN_DIV
                              + (`SHOW_UNIT * `SCAN_DIV << (`PLANES - 1));

    typedef struct packed {
        logic       fill; // write every pixel with random data
        logic [7:0] op;
        logic [7:0] arg0;
        logic [7:0] arg1;
        logic [1:0] nargs;
        logic [2:0] rgb_en; // expected enables after the command
        logic [1:0] plane_en;
        logic [7:0] passes;
    } test_entry_t;

    logic                    clk_root = 1'b0;
    logic                    rst;
    logic                    uart_line;
    panel_pkg::panel_drive_t panel;

    logic [15:0] lfsr_state;
    logic [5:0]  shadow_top [`HALF_ROWS * `PANEL_COLS];
    logic [5:0]  shadow_bot [`HALF_ROWS * `PANEL_COLS];
    logic [2:0]  model_rgb_en;
    logic [1:0]  model_plane_en;
    logic [2:0]  cap_top [`PANEL_COLS]; // columns seen in the current pass
    logic [2:0]  cap_bot [`PANEL_COLS];
    logic        armed;
    logic        pass_armed;
    logic        prev_clk, prev_latch, prev_oe;
    int          col_cnt, oe_cnt, exp_row, exp_plane;
    int          checked_passes;
    int          error_count;
    int          failed_tests;

    led_panel_top i_led_panel_top (
        .clk_root  (clk_root),
        .rst       (rst),
        .uart_line (uart_line),
        .panel     (panel)
    );

    always #10 clk_root = ~clk_root;

    function automatic test_entry_t stimulus_table(input int idx);
        test_entry_t e;
        case (idx)
            0: e = '{1'b1, 8'h00, 8'h00, 8'h00, 2'd0, 3'b111, 2'b11, 8'd8};
            1: e = '{1'b0, 8'h45, 8'h06, 8'h00, 2'd1, 3'b110, 2'b11, 8'd8};
            2: e = '{1'b0, 8'h45, 8'h07, 8'h00, 2'd1, 3'b111, 2'b11, 8'd8};
            3: e = '{1'b0, 8'h42, 8'h02, 8'h00, 2'd1, 3'b111, 2'b10, 8'd8};
            4: e = '{1'b0, 8'h42, 8'h03, 8'h00, 2'd1, 3'b111, 2'b11, 8'd8};
            5: e = '{1'b0, 8'h58, 8'h13, 8'h2a, 2'd2, 3'b111, 2'b11, 8'd8}; // 'X' unknown
            default: e = '{1'b0, 8'h50, 8'h47, 8'h2d, 2'd2, 3'b111, 2'b11, 8'd8};
        endcase
        return e;
    endfunction

    function automatic string test_name(input int idx);
        case (idx)
            0: return "random pixel fill";
            1: return "rgb enable green and blue";
            2: return "rgb enable all";
            3: return "plane 0 disabled";
            4: return "planes restored";
            5: return "unknown opcode";
            default: return "single pixel write";
        endcase
    endfunction

    // galois lfsr stepped once per bit taken
    function automatic logic lfsr_step();
        logic b;
        b = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (b) lfsr_state = lfsr_state ^ 16'hb400;
        return b;
    endfunction

    function automatic logic [5:0] random_pixel();
        logic [5:0] px;
        px = '0;
        for (int i = 0; i < 6; i++) px = {px[4:0], lfsr_step()};
        return px;
    endfunction

    // plane bit of each channel gated by both enables
    function automatic logic [2:0] expected_bits(input logic [5:0] px, input int pl);
        logic [2:0] bits;
        bits = {px[4 + pl], px[2 + pl], px[pl]};
        return bits & model_rgb_en & {3{model_plane_en[pl]}};
    endfunction

    task automatic report_error(input string msg);
        $display("** Error at %0t ns: %s", $time, msg);
        error_count++;
    endtask

    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0}; // stop, data lsb first, start
        for (int i = 0; i < 10; i++) begin
            @(posedge clk_root);
            #2 uart_line = frame[i];
            repeat (`UART_TICKS_PER_BIT - 1) @(posedge clk_root);
        end
    endtask

    task automatic write_pixel(input logic [6:0] addr, input logic [5:0] px);
        send_byte(8'h50);
        send_byte({1'b0, addr});
        send_byte({2'b00, px});
        if (addr[6]) shadow_bot[addr[5:0]] = px;
        else shadow_top[addr[5:0]] = px;
    endtask

    task automatic apply_entry(input test_entry_t e);
        if (e.fill) begin
            for (int a = 0; a < 2 * `HALF_ROWS * `PANEL_COLS; a++) begin
                write_pixel(7'(a), random_pixel());
            end
        end else if (e.op == 8'h50) begin
            write_pixel(e.arg0[6:0], e.arg1[5:0]);
        end else begin
            send_byte(e.op);
            if (e.nargs >= 2'd1) send_byte(e.arg0);
            if (e.nargs >= 2'd2) send_byte(e.arg1);
        end
        model_rgb_en = e.rgb_en;
        model_plane_en = e.plane_en;
    endtask

    task automatic wait_latch();
        @(negedge clk_root);
        while (!panel.latch) @(negedge clk_root);
    endtask

    // compare the shifted row pair with the shadow model at the end of a pass
    task automatic check_pass();
        int idx;
        assert (col_cnt == `PANEL_COLS) else
            report_error($sformatf("latch after %0d columns", col_cnt));
        assert (panel.row_addr == exp_row[1:0]) else
            report_error($sformatf("row_addr %0d, expected %0d", panel.row_addr, exp_row));
        if (pass_armed) begin
            for (int c = 0; c < `PANEL_COLS; c++) begin
                idx = exp_row * `PANEL_COLS + c;
                assert (cap_top[c] == expected_bits(shadow_top[idx], exp_plane)) else
                    report_error($sformatf("row %0d plane %0d col %0d top %b, expected %b",
                        exp_row, exp_plane, c, cap_top[c],
                        expected_bits(shadow_top[idx], exp_plane)));
                assert (cap_bot[c] == expected_bits(shadow_bot[idx], exp_plane)) else
                    report_error($sformatf("row %0d plane %0d col %0d bottom %b, expected %b",
                        exp_row, exp_plane, c, cap_bot[c],
                        expected_bits(shadow_bot[idx], exp_plane)));
            end
            checked_passes++;
        end
        col_cnt = 0;
        pass_armed = 1'b0;
    endtask

    // panel monitor sampled on the falling edge
    always @(negedge clk_root) begin
        if (rst) begin
            col_cnt = 0;
            oe_cnt = 0;
            exp_row = 0;
            exp_plane = 0;
            pass_armed = 1'b0;
            prev_clk = 1'b0;
            prev_latch = 1'b0;
            prev_oe = 1'b0;
        end else begin
            assert (panel.spare == 1'b0) else
                report_error("spare bit of the panel bundle is not 0");
            if (panel.clk_pixel && !prev_clk) begin
                if (col_cnt == 0) pass_armed = armed;
                if (col_cnt < `PANEL_COLS) begin
                    cap_top[col_cnt] = panel.rgb_top;
                    cap_bot[col_cnt] = panel.rgb_bottom;
                end
                col_cnt++;
            end
            if (panel.latch && !prev_latch) check_pass();
            if (panel.output_enable) begin
                oe_cnt++;
            end else if (prev_oe) begin
                assert (oe_cnt == (`SHOW_UNIT * `SCAN_DIV << exp_plane)) else
                    report_error($sformatf("plane %0d shown %0d cycles", exp_plane, oe_cnt));
                oe_cnt = 0;
                exp_plane++;
                if (exp_plane == `PLANES) begin
                    exp_plane = 0;
                    exp_row = (exp_row + 1) % `HALF_ROWS;
                end
            end
            prev_clk = panel.clk_pixel;
            prev_latch = panel.latch;
            prev_oe = panel.output_enable;
        end
    end

    initial begin
        int budget;
        test_entry_t e;
        budget = 20;
        for (int t = 0; t < NUM_TESTS; t++) begin
            e = stimulus_table(t);
            budget += (e.fill ? 384 : 1 + e.nargs) * 10 * `UART_TICKS_PER_BIT;
            budget += (e.passes + 3) * PASS_MAX;
        end
        repeat (budget * 3) @(posedge clk_root);
        $display("watchdog: simulation did not finish in time");
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        int start_err;
        test_entry_t e;
        rst = 1'b1;
        uart_line = 1'b1; // line idle
        lfsr_state = 16'd52;
        model_rgb_en = 3'b111;
        model_plane_en = 2'b11;
        armed = 1'b0;
        checked_passes = 0;
        error_count = 0;
        failed_tests = 0;
        repeat (10) @(posedge clk_root);
        #2 rst = 1'b0;
        @(negedge clk_root);
        assert (!panel.output_enable && !panel.latch && !panel.clk_pixel) else
            report_error("panel strobes not low after reset");

        for (int t = 0; t < NUM_TESTS; t++) begin
            e = stimulus_table(t);
            start_err = error_count;
            apply_entry(e);
            repeat (4) @(posedge clk_root);
            wait_latch(); // passes from here on start after the command
            checked_passes = 0;
            armed = 1'b1;
            wait (checked_passes >= e.passes);
            armed = 1'b0;
            if (error_count == start_err) begin
                $display("test %0d %s: ok", t, test_name(t));
            end else begin
                failed_tests++;
                $display("test %0d %s: %0d errors", t, test_name(t), error_count - start_err);
            end
        end

        $display("tests run %0d, failed %0d, errors %0d", NUM_TESTS, failed_tests, error_count);
        if (error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+logic
logic/panel_pkg.sv
logic/cmd_pkg.sv
logic/uart_rx.sv
logic/cmd_decoder.sv
logic/frame_ram.sv
logic/matrix_scan.sv
logic/frame_fetch.sv
logic/led_panel_top.sv
tests/tb_led_panel.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the led panel testbench with Verilator
set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f compile.f \
    --top-module tb_led_panel --Mdir obj_dir -o tb_led_panel
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_led_panel > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q ">>> FAIL" "$LOG"; then
    exit 1
fi
exit 0
